// ==== verilog.f ====
+incdir+hdl
hdl/rxdma_pkg.sv
hdl/rxdma_fifo.sv
hdl/rx_byte_packer.sv
hdl/rx_dma_engine.sv
hdl/eth_rx_dma.sv
tests/tb_eth_rx_dma.sv

// ==== tests/tb_eth_rx_dma.sv ====
/*
 * Receive DMA testbench
 * Table of frames sent through the byte stream, with models of the descriptor
 * RAM and the memory, and a reference model that checks data, writebacks,
 * descriptor index and interrupts
 */
`timescale 1ns/100ps
`include "rxdma_config.svh"

module tb_eth_rx_dma;

    import rxdma_pkg::*;

    localparam int NUM_FRAMES = 15;
    localparam int GAP        = 10;             // Idle cycles between frames
    localparam int MAX_BD     = 3;

    typedef struct packed {
        length_t    len;
        rx_status_t err;                        // MAC status on end byte
        logic       irq;
        logic       wrap;
        rx_word_t   ptr;
        logic       stall;                      // waitrequest held high
        logic       busy;                       // Refused, no writeback
        logic       ovr;                        // Expect overrun
    } frame_t;

    logic clk, reset, rx_en, rx_dv, rx_sop, rx_eop, bd_wait, av_waitrequest;
    logic [7:0] rx_data;
    rx_status_t rx_err;
    bd_index_t  max_rx_bd, bd_index;
    bd_word_t   bd_desc, bd_writedata;
    rx_word_t   bd_ptr, av_address, av_writedata;
    logic bd_read, bd_write, av_write, rxb_irq, rxe_irq, busy_irq;
    logic [3:0] av_byteenable;

    frame_t     tbl [NUM_FRAMES];
    int         wb_rows [NUM_FRAMES];           // Rows that get a writeback, in order
    logic [7:0] frame_bytes [NUM_FRAMES][64];
    rx_word_t   mem_data [1024];                // 4 KB buffer area
    logic [3:0] mem_be [1024];
    logic [15:0] data_lfsr = 16'd27503;
    logic [15:0] bp_lfsr   = 16'd27503;
    logic stall_hold = 1'b0, table_ready = 1'b0, exp_rxb = 1'b0, exp_rxe = 1'b0;
    bd_index_t exp_idx = '0;
    int errors = 0, wb_cnt = 0, sent_wb = 0, n_wb = 0, n_busy = 0;
    int busy_seen = 0, mem_writes = 0, total_len = 0;

    eth_rx_dma dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    // **************************************************
    // Random source and compare tasks
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);     // Galois, 16 bit
    endfunction

    task automatic rand_bits(input int n, inout logic [15:0] st, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[6:0], st[0]};               // One step per bit
            st = lfsr_next(st);
        end
    endtask

    task automatic check_word(input string what, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bd(input string what, input bd_word_t got, input bd_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_index(input bd_index_t got, input bd_index_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: bd_index is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_be(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: byteenable is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // **************************************************
    // Frame table
    task automatic set_row(input int i, input int len, input int err, input int irq,
                           input int wrap, input int ptr, input int stall, input int busy,
                           input int ovr);
        tbl[i] = '{len: length_t'(len), err: rx_status_t'(err), irq: irq[0], wrap: wrap[0],
                   ptr: rx_word_t'(ptr), stall: stall[0], busy: busy[0], ovr: ovr[0]};
        total_len += len;
        if (busy != 0) begin
            n_busy++;
        end else begin
            wb_rows[n_wb] = i;
            n_wb++;
        end
    endtask

    task automatic load_table();
        //  row len  err    irq wrap ptr   stall busy ovr
        set_row(0,  13, 'h000, 1, 0, 'h000, 0, 0, 0);
        set_row(1,   4, 'h000, 0, 0, 'h100, 0, 0, 0);
        set_row(2,   1, 'h004, 1, 0, 'h200, 0, 0, 0);  // Short frame only, clean
        set_row(3,  22, 'h050, 1, 0, 'h300, 0, 0, 0);  // MAC bit 6 gets replaced
        set_row(4,   7, 'h000, 1, 0, 'h400, 0, 0, 0);
        set_row(5,  30, 'h001, 0, 1, 'h500, 0, 0, 0);  // Wrap at index 1
        set_row(6,   4, 'h000, 1, 0, 'h600, 1, 0, 0);  // Four frames fill status FIFO
        set_row(7,   4, 'h100, 1, 0, 'h640, 1, 0, 0);
        set_row(8,   4, 'h000, 0, 0, 'h680, 1, 0, 0);
        set_row(9,   4, 'h000, 1, 0, 'h6C0, 1, 0, 0);
        set_row(10,  8, 'h000, 1, 0, 'h000, 1, 1, 0);  // Start byte while full
        set_row(11,  9, 'h000, 1, 0, 'h700, 0, 0, 0);
        set_row(12, 48, 'h000, 1, 0, 'h800, 1, 0, 1);  // Data FIFO overrun
        set_row(13, 17, 'h000, 1, 0, 'h900, 0, 0, 0);
        set_row(14, 64, 'h002, 1, 0, 'hA00, 0, 0, 0);
        for (int i = 0; i < 1024; i++)
            mem_be[i] = 4'h0;
    endtask

    // **************************************************
    // Stream driver
    task automatic send_frame(input int f);
        logic [7:0] v;
        for (int b = 0; b < tbl[f].len; b++) begin
            @(posedge clk);
            #1;
            rand_bits(8, data_lfsr, v);
            frame_bytes[f][b] = v;
            rx_dv   = 1'b1;
            rx_data = v;
            rx_sop  = (b == 0);
            rx_eop  = (b == tbl[f].len - 1);
            rx_err  = rx_eop ? tbl[f].err : '0;
        end
        @(posedge clk);
        #1;
        {rx_dv, rx_sop, rx_eop, rx_err} = '0;
        repeat (GAP) @(posedge clk);
    endtask

    task automatic wait_drain();
        wait (wb_cnt == sent_wb);               // All accepted frames written back
        repeat (4) @(posedge clk);
    endtask

    // Descriptor RAM and waitrequest, driven after the edge
    initial begin : bus_model
        logic [7:0] v;
        int r;
        forever begin
            @(posedge clk);
            #1;
            rand_bits(2, bp_lfsr, v);
            av_waitrequest = stall_hold | (&v[1:0]);    // 1 in 4 random gaps
            rand_bits(2, bp_lfsr, v);
            bd_wait = &v[1:0];
            bd_desc = '0;
            if (wb_cnt < n_wb) begin
                r = wb_rows[wb_cnt];
                bd_desc[`RXDMA_BIT_EMPTY] = 1'b1;       // Every descriptor free
                bd_desc[`RXDMA_BIT_IRQ]   = tbl[r].irq;
                bd_desc[`RXDMA_BIT_WRAP]  = tbl[r].wrap;
                bd_ptr = tbl[r].ptr;
            end
        end
    end

    // **************************************************
    // Monitors, sampled on the falling edge
    task automatic store_write();
        int a;
        if (av_address[31:12] != 0 || av_address[1:0] != 0) begin
            errors++;
            $display("Memory write to %h at %0t ns is outside the buffers", av_address, $time);
        end else begin
            a = av_address[11:2];
            for (int k = 0; k < 4; k++)
                if (av_byteenable[k])
                    mem_data[a][8*k +: 8] = av_writedata[8*k +: 8];
            mem_be[a] = av_byteenable;
        end
        mem_writes++;
    endtask

    task automatic check_writeback();
        int r, a, rem;
        length_t len;
        rx_status_t st;
        bd_word_t exp;
        logic [3:0] be;
        rx_word_t ew, mask;
        logic err_flag;
        if (wb_cnt >= n_wb) begin
            errors++;
            $display("Descriptor writeback at %0t ns with no frame left to write", $time);
            return;
        end
        r   = wb_rows[wb_cnt];
        len = tbl[r].len;
        if (tbl[r].ovr)
            len = length_t'(4 * (`RXDMA_DATA_DEPTH + 1));  // Full data FIFO plus held word
        st = tbl[r].err;
        st[`RXDMA_STAT_OVERRUN] = tbl[r].ovr;
        exp = '0;
        exp[`RXDMA_LEN_LSB +: 16] = len;
        exp[`RXDMA_BIT_IRQ]  = tbl[r].irq;
        exp[`RXDMA_BIT_WRAP] = tbl[r].wrap;
        exp[8:0] = st;
        check_bd("writeback word", bd_writedata, exp);
        check_index(bd_index, exp_idx);
        exp_idx = (exp_idx == MAX_BD || tbl[r].wrap) ? bd_index_t'(0) : exp_idx + 1'b1;
        for (int w = 0; w < (len + 3) / 4; w++) begin
            a   = (tbl[r].ptr >> 2) + w;
            rem = len - 4 * w;
            be  = (rem >= 4) ? 4'hF : 4'((1 << rem) - 1);     // Partial last word
            ew   = '0;
            mask = '0;
            for (int k = 0; k < 4; k++)
                if (be[k]) begin
                    ew[8*k +: 8]   = frame_bytes[r][4*w + k];
                    mask[8*k +: 8] = 8'hFF;
                end
            check_be(mem_be[a], be);
            check_word("memory word", mem_data[a] & mask, ew);
            mem_be[a] = 4'h0;
        end
        st[`RXDMA_STAT_SHORT] = 1'b0;               // Short frame alone is no error
        err_flag = |st;
        exp_rxb  = tbl[r].irq && !err_flag;
        exp_rxe  = tbl[r].irq && err_flag;
        wb_cnt++;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_flag("rxb_irq", rxb_irq, exp_rxb);      // Pulse one cycle after writeback
            check_flag("rxe_irq", rxe_irq, exp_rxe);
            exp_rxb = 1'b0;
            exp_rxe = 1'b0;
            if (busy_irq)
                busy_seen++;
            if (av_write && !av_waitrequest)
                store_write();
            if (bd_read && !bd_wait)
                check_index(bd_index, exp_idx);         // Fetch at the next index
            if (bd_write && !bd_wait)
                check_writeback();
        end
    end

    // Watchdog, scaled to the table
    initial begin
        wait (table_ready);
        repeat (total_len * 40 + 2000) @(posedge clk);
        $display("Timeout after %0d cycles, the DMA stopped making progress",
                 total_len * 40 + 2000);
        $display("Test failed");
        $finish;
    end

    // **************************************************
    // Main sequence
    initial begin : stimulus
        reset = 1'b1;
        rx_en = 1'b0;
        {rx_dv, rx_sop, rx_eop, rx_data, rx_err} = '0;
        max_rx_bd      = bd_index_t'(MAX_BD);
        bd_desc        = '0;
        bd_ptr         = '0;
        bd_wait        = 1'b0;
        av_waitrequest = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        rx_en = 1'b1;
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (tbl[i].stall != stall_hold) begin
                if (!tbl[i].stall)
                    stall_hold = 1'b0;          // Release before draining
                wait_drain();
                stall_hold = tbl[i].stall;
            end
            send_frame(i);
            if (!tbl[i].busy)
                sent_wb++;
        end
        stall_hold = 1'b0;
        wait_drain();
        repeat (20) @(posedge clk);
        if (busy_seen != n_busy) begin
            errors++;
            $display("busy_irq pulsed %0d times but %0d frames were refused", busy_seen, n_busy);
        end
        $display("Summary: %0d errors, %0d writebacks, %0d memory writes, %0d busy pulses",
                 errors, wb_cnt, mem_writes, busy_seen);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== hdl/eth_rx_dma.sv ====
/*
 * Ethernet receive DMA, top level
 * Byte packer, data and status FIFOs, DMA engine
 */
`timescale 1ns/100ps
`include "rxdma_config.svh"

module eth_rx_dma (
    input  logic                  clk,
    input  logic                  reset,
    // Receive stream
    input  logic                  rx_en,
    input  logic [7:0]            rx_data,
    input  logic                  rx_dv,
    input  logic                  rx_sop,
    input  logic                  rx_eop,
    input  rxdma_pkg::rx_status_t rx_err,
    // Descriptor RAM
    input  rxdma_pkg::bd_index_t  max_rx_bd,
    input  rxdma_pkg::bd_word_t   bd_desc,
    input  rxdma_pkg::rx_word_t   bd_ptr,
    input  logic                  bd_wait,
    output logic                  bd_read,
    output logic                  bd_write,
    output rxdma_pkg::bd_index_t  bd_index,
    output rxdma_pkg::bd_word_t   bd_writedata,
    // Memory
    input  logic                  av_waitrequest,
    output logic                  av_write,
    output rxdma_pkg::rx_word_t   av_address,
    output rxdma_pkg::rx_word_t   av_writedata,
    output logic [3:0]            av_byteenable,
    // Interrupts
    output logic                  rxb_irq,
    output logic                  rxe_irq,
    output logic                  busy_irq
);

    import rxdma_pkg::*;

    data_entry_t dff_din, dff_dout;         // Data FIFO
    rx_status_t  sff_din, sff_dout;         // Status FIFO
    logic        dff_wr, dff_full, dff_rd, dff_empty;
    logic        sff_wr, sff_full, sff_rd, sff_empty;

    rx_byte_packer packer_i (
        .clk, .reset, .rx_data, .rx_dv, .rx_sop, .rx_eop, .rx_err,
        .data_full (dff_full), .stat_full (sff_full),
        .data_wr (dff_wr), .data_entry (dff_din),
        .stat_wr (sff_wr), .stat_entry (sff_din), .busy_irq
    );

    rxdma_fifo #(.payload_t(data_entry_t), .DEPTH(`RXDMA_DATA_DEPTH)) data_fifo_i (
        .clk, .reset, .wr (dff_wr), .din (dff_din), .full (dff_full),
        .rd (dff_rd), .dout (dff_dout), .empty (dff_empty)
    );

    rxdma_fifo #(.payload_t(rx_status_t), .DEPTH(`RXDMA_STAT_DEPTH)) stat_fifo_i (
        .clk, .reset, .wr (sff_wr), .din (sff_din), .full (sff_full),
        .rd (sff_rd), .dout (sff_dout), .empty (sff_empty)
    );

    rx_dma_engine engine_i (
        .clk, .reset, .rx_en, .max_rx_bd,
        .bd_desc, .bd_ptr, .bd_wait, .bd_read, .bd_write, .bd_index, .bd_writedata,
        .data_entry (dff_dout), .data_empty (dff_empty), .data_rd (dff_rd),
        .stat_entry (sff_dout), .stat_empty (sff_empty), .stat_rd (sff_rd),
        .av_waitrequest, .av_write, .av_address, .av_writedata, .av_byteenable,
        .rxb_irq, .rxe_irq
    );

endmodule

// ==== hdl/rx_dma_engine.sv ====
/*
 * Receive DMA engine
 * Reads a free descriptor, moves frame words from the data FIFO to memory,
 * writes back length and status, steps the descriptor index, raises interrupts
 */
`timescale 1ns/100ps
`include "rxdma_config.svh"

module rx_dma_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx_en,
    input  rxdma_pkg::bd_index_t   max_rx_bd,       // Highest descriptor index
    input  rxdma_pkg::bd_word_t    bd_desc,
    input  rxdma_pkg::rx_word_t    bd_ptr,
    input  logic                   bd_wait,         // Descriptor RAM busy
    output logic                   bd_read,
    output logic                   bd_write,
    output rxdma_pkg::bd_index_t   bd_index,
    output rxdma_pkg::bd_word_t    bd_writedata,
    input  rxdma_pkg::data_entry_t data_entry,
    input  logic                   data_empty,
    output logic                   data_rd,
    input  rxdma_pkg::rx_status_t  stat_entry,
    input  logic                   stat_empty,
    output logic                   stat_rd,
    input  logic                   av_waitrequest,
    output logic                   av_write,
    output rxdma_pkg::rx_word_t    av_address,
    output rxdma_pkg::rx_word_t    av_writedata,
    output logic [3:0]             av_byteenable,
    output logic                   rxb_irq,
    output logic                   rxe_irq
);

    import rxdma_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_BD_RD, ST_DATA, ST_STAT, ST_WB} state_t;

    // Status bits that count as errors
    localparam rx_status_t ERR_MASK = ~(rx_status_t'(1) << `RXDMA_STAT_SHORT);

    state_t     state;
    rx_word_t   ptr_r;          // Next write address
    length_t    len_r;          // Bytes written
    rx_status_t status_r;
    logic       desc_irq;
    logic       desc_wrap;
    logic       err_r;
    logic       pre_write;      // Word ready for memory stage
    logic       mem_idle;       // No write left pending
    logic       bd_take;        // Free descriptor accepted
    logic       bd_done;        // Writeback accepted
    logic [3:0] be_last;

    assign bd_read   = (state == ST_BD_RD);
    assign bd_write  = (state == ST_WB);
    assign bd_take   = bd_read && !bd_wait && bd_desc[`RXDMA_BIT_EMPTY];
    assign bd_done   = bd_write && !bd_wait;
    assign pre_write = (state == ST_DATA) && !data_empty;
    assign data_rd   = pre_write && !av_waitrequest;
    assign mem_idle  = !av_write || !av_waitrequest;
    assign stat_rd   = (state == ST_STAT) && !stat_empty && mem_idle;
    assign be_last   = 4'b1111 >> (2'd3 - data_entry.cnt);

    // **************************************************
    // DMA FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (rx_en) state <= ST_BD_RD;
                ST_BD_RD: if (!rx_en)
                        state <= ST_IDLE;
                    else if (bd_take)
                        state <= ST_DATA;               // Not empty, keep polling
                ST_DATA:  if (data_rd && data_entry.last) state <= ST_STAT;
                ST_STAT:  if (stat_rd) state <= ST_WB;
                ST_WB:    if (bd_done) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Descriptor fields, address and length
    always_ff @(posedge clk) begin
        if (bd_take) begin
            ptr_r     <= bd_ptr;
            desc_irq  <= bd_desc[`RXDMA_BIT_IRQ];
            desc_wrap <= bd_desc[`RXDMA_BIT_WRAP];
            len_r     <= '0;
        end else if (data_rd) begin
            ptr_r <= ptr_r + 32'd4;
            len_r <= len_r + length_t'(data_entry.cnt) + 16'd1;
        end
        if (stat_rd) begin
            status_r <= stat_entry;
            err_r    <= |(stat_entry & ERR_MASK);      // Short frame alone is clean
        end
    end

    // **************************************************
    // Memory write stage, holds under waitrequest
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            av_write <= 1'b0;
        else if (!av_waitrequest)
            av_write <= pre_write;
    end

    always_ff @(posedge clk) begin
        if (!av_waitrequest) begin
            av_address    <= ptr_r;
            av_writedata  <= data_entry.data;
            av_byteenable <= data_entry.last ? be_last : 4'b1111;
        end
    end

    // **************************************************
    // Writeback word, empty bit and reserved bits zero
    always_comb begin
        bd_writedata = '0;
        bd_writedata[`RXDMA_LEN_LSB +: $bits(length_t)] = len_r;
        bd_writedata[`RXDMA_BIT_IRQ]  = desc_irq;
        bd_writedata[`RXDMA_BIT_WRAP] = desc_wrap;
        bd_writedata[$bits(rx_status_t)-1:0] = status_r;
    end

    // Index and interrupt pulses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bd_index <= '0;
            rxb_irq  <= 1'b0;
            rxe_irq  <= 1'b0;
        end else begin
            rxb_irq <= bd_done && desc_irq && !err_r;
            rxe_irq <= bd_done && desc_irq && err_r;
            if (!rx_en)
                bd_index <= '0;                         // Held while disabled
            else if (bd_done)
                bd_index <= ((bd_index == max_rx_bd) || desc_wrap) ? '0 : bd_index + 1'b1;
        end
    end

    a_ptr_aligned: assert property (@(posedge clk) disable iff (reset)
        bd_take |-> (bd_ptr[1:0] == 2'b00));
    // Last memory write done before the descriptor goes back
    a_wb_after_data: assert property (@(posedge clk) disable iff (reset)
        bd_write |-> !av_write);

endmodule

// ==== hdl/rx_byte_packer.sv ====
/*
 * Receive byte packer
 * Packs the MAC byte stream into 32-bit data FIFO entries, writes one status
 * entry per frame, discards the frame tail on overrun, flags busy frames
 */
`timescale 1ns/100ps
`include "rxdma_config.svh"

module rx_byte_packer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             rx_data,
    input  logic                   rx_dv,       // Qualifies data and flags
    input  logic                   rx_sop,
    input  logic                   rx_eop,
    input  rxdma_pkg::rx_status_t  rx_err,      // Sampled on end byte
    input  logic                   data_full,
    input  logic                   stat_full,
    output logic                   data_wr,
    output rxdma_pkg::data_entry_t data_entry,
    output logic                   stat_wr,
    output rxdma_pkg::rx_status_t  stat_entry,
    output logic                   busy_irq
);

    import rxdma_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_RECV, ST_DISC, ST_END} state_t;

    state_t     state;
    byte_cnt_t  pos;            // Next byte lane
    byte_cnt_t  idx;            // Lane for this byte
    byte_cnt_t  last_cnt;       // Lane of last stored byte
    rx_word_t   word_r;         // Word under assembly
    rx_status_t err_r;          // MAC status of frame
    logic       wr_pend;        // Full word due this cycle
    logic       overrun;
    logic       fifo_full;
    logic       word_stall;     // Word due but no room
    logic       accept;         // Byte goes into word_r

    assign fifo_full  = data_full | stat_full;
    assign word_stall = (state == ST_RECV) && wr_pend && fifo_full;
    assign idx        = (state == ST_IDLE) ? byte_cnt_t'(2'd0) : pos;
    assign accept     = rx_dv && (((state == ST_IDLE) && rx_sop && !fifo_full) ||
                                  ((state == ST_RECV) && !word_stall));

    // **************************************************
    // FIFO write side
    assign data_wr = ((state == ST_RECV) && wr_pend && !fifo_full) ||
                     ((state == ST_END) && !fifo_full);
    assign stat_wr = (state == ST_END) && !fifo_full;

    always_comb begin
        data_entry.data = word_r;
        data_entry.last = (state == ST_END);
        data_entry.cnt  = (state == ST_END) ? last_cnt : byte_cnt_t'(2'd3);
        stat_entry      = err_r;
        stat_entry[`RXDMA_STAT_OVERRUN] = overrun;     // Overrun replaces MAC bit
    end

    // **************************************************
    // Receive FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            pos      <= '0;
            wr_pend  <= 1'b0;
            overrun  <= 1'b0;
            busy_irq <= 1'b0;
        end else begin
            busy_irq <= 1'b0;                           // One-cycle pulses
            wr_pend  <= 1'b0;
            case (state)
                ST_IDLE: if (rx_dv && rx_sop) begin
                    if (fifo_full) begin
                        busy_irq <= 1'b1;               // No room, frame dropped
                    end else begin
                        overrun <= 1'b0;
                        pos     <= 2'd1;
                        state   <= rx_eop ? ST_END : ST_RECV;
                    end
                end
                ST_RECV: if (word_stall) begin
                    overrun <= 1'b1;                    // Keep the stalled word
                    state   <= (rx_dv && rx_eop) ? ST_END : ST_DISC;
                end else if (rx_dv) begin
                    pos     <= pos + 2'd1;
                    wr_pend <= (pos == 2'd3) && !rx_eop;    // Fourth byte
                    if (rx_eop)
                        state <= ST_END;
                end
                ST_DISC: if (rx_dv && rx_eop)
                    state <= ST_END;                    // Drop bytes to end
                ST_END: if (!fifo_full)
                    state <= ST_IDLE;                   // Last word and status out
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte lanes and frame status
    always_ff @(posedge clk) begin
        if (accept) begin
            word_r[idx*8 +: 8] <= rx_data;
            last_cnt           <= idx;
        end
        if (rx_dv && rx_eop && (state != ST_END))
            err_r <= rx_err;
    end

    // Mid-frame words leave only once all four lanes are filled
    a_full_word: assert property (@(posedge clk) disable iff (reset)
        (data_wr && !data_entry.last) |-> (pos == 2'd0));

endmodule

// ==== hdl/rxdma_fifo.sv ====
/*
 * Single-clock FIFO
 * Circular buffer with occupancy count, payload type set by parameter,
 * head visible on dout while not empty
 */
`timescale 1ns/100ps

module rxdma_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr,        // Push din
    input  payload_t din,
    output logic     full,
    input  logic     rd,        // Pop head
    output payload_t dout,      // Current head
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;   // Entries held

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    // Storage, no reset on payload
    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_ptr] <= din;
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // Callers must respect the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd |-> !empty);

endmodule

// ==== hdl/rxdma_pkg.sv ====
/*
 * Receive DMA shared types
 * Memory word, frame status, FIFO data entry, descriptor word,
 * descriptor index and frame length
 */
`include "rxdma_config.svh"

package rxdma_pkg;

    // Memory word, byte 0 in bits 7:0 is the first received byte
    typedef logic [31:0] rx_word_t;

    // MAC error bits with bit 6 carrying FIFO overrun
    typedef logic [8:0] rx_status_t;

    // Valid bytes in a word minus one
    typedef logic [1:0] byte_cnt_t;

    // Data FIFO entry, 35 bits
    typedef struct packed {
        rx_word_t  data;    // Packed bytes
        logic      last;    // Last word of frame
        byte_cnt_t cnt;     // Valid byte count minus one
    } data_entry_t;

    // Descriptor control word
    typedef logic [31:0] bd_word_t;

    // Descriptor index
    typedef logic [`RXDMA_INDEX_W-1:0] bd_index_t;

    // Frame length in bytes
    typedef logic [15:0] length_t;

endpackage

// ==== hdl/rxdma_config.svh ====
/*
 * Receive DMA configuration
 * FIFO depths, descriptor bit positions, status bit positions and index width
 */
`ifndef RXDMA_CONFIG_SVH
`define RXDMA_CONFIG_SVH

// FIFO sizing
`define RXDMA_DATA_DEPTH    8       // Data FIFO depth in 32-bit words
`define RXDMA_STAT_DEPTH    4       // Status FIFO depth, one entry per frame

// Descriptor control word layout
`define RXDMA_BIT_EMPTY     15      // 1 = buffer free for the DMA
`define RXDMA_BIT_IRQ       14      // Interrupt at end of frame
`define RXDMA_BIT_WRAP      13      // Next descriptor is index 0
`define RXDMA_LEN_LSB       16      // Low bit of 16-bit length field

// Per-frame status bits
`define RXDMA_STAT_OVERRUN  6       // Replaces MAC bit 6
`define RXDMA_STAT_SHORT    2       // Short frame, not an error

`define RXDMA_INDEX_W       7       // Descriptor index width

`endif
